/* Makefile */
TOP := tb_titan_lsu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f titan_lsu.f --top-module $(TOP)

sim:
	verilator --binary --timing -f titan_lsu.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log || (echo "No pass message in log"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* tb_titan_lsu.sv */
`default_nettype none

`include "titan_cfg.svh"

module tb_titan_lsu;
  timeunit 1ns;
  timeprecision 1ps;
  import titan_pkg::*;

  localparam int PERIOD     = 20;
  localparam int WAIT_LIMIT = 50;
  localparam int MEM_BYTES  = `TITAN_MEM_WORDS * 4;

  logic       clk_i;
  logic       rst_i;
  addr_t      pc_i;
  logic       ikill_i;
  mem_req_t   mreq;
  word_t      instr_o;
  word_t      data_o;
  logic       istall_o;
  logic       ierr_o;
  logic       dstall_o;
  logic       derr_o;
  logic [7:0] model_mem [MEM_BYTES];
  word_t      rng;
  int         errors;
  int         checks;
  int         tests;

  titan_lsu_top u_dut (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .pc_i     (pc_i),
    .ikill_i  (ikill_i),
    .instr_o  (instr_o),
    .istall_o (istall_o),
    .ierr_o   (ierr_o),
    .mreq_i   (mreq),
    .data_o   (data_o),
    .dstall_o (dstall_o),
    .derr_o   (derr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  // Backstop for the whole run
  initial begin
    #(PERIOD * 20000);
    $display("Simulation ran past its time limit");
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic word_t next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic addr_t rand_word_addr();
    return (next_rand() % word_t'(`TITAN_MEM_WORDS)) << 2;
  endfunction

  // Little endian, byte 0 in bits 7..0
  function automatic word_t model_word(input addr_t addr);
    int a;
    a = int'(addr);
    return {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]};
  endfunction

  task automatic model_store(input addr_t addr, input word_t data, input size_t size);
    int a;
    int n;
    a = int'(addr);
    n = (size == `TITAN_SIZE_BYTE) ? 1 : (size == `TITAN_SIZE_HALF) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      model_mem[a + i] = data[8*i +: 8];
    end
  endtask

  function automatic word_t expect_load(input addr_t addr, input size_t size, input logic uns);
    int          a;
    logic [7:0]  b;
    logic [15:0] h;
    a = int'(addr);
    b = model_mem[a];
    if (size == `TITAN_SIZE_BYTE) begin
      return uns ? {24'h0, b} : {{24{b[7]}}, b};
    end
    if (size == `TITAN_SIZE_HALF) begin
      h = {model_mem[a + 1], b};
      return uns ? {16'h0, h} : {{16{h[15]}}, h};
    end
    return model_word(addr);
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s at %0t: got %h, expected %h", name, $time, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s at %0t: got %h, expected %h", name, $time, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int start);
    tests++;
    $display("%-16s done, %0d error(s)", name, errors - start);
  endtask

  // One request on the data port, held until the stall drops
  task automatic data_access(input addr_t addr, input word_t wdata, input size_t size,
                             input logic uns, input logic write,
                             output word_t rdata, output logic err);
    mem_req_t req;
    int       cycles;
    logic     done;
    req             = '0;
    req.addr        = addr;
    req.wdata       = wdata;
    req.size        = size;
    req.is_unsigned = uns;
    req.read        = !write;
    req.write       = write;
    rdata  = '0;
    err    = 1'b0;
    cycles = 0;
    done   = 1'b0;
    @(negedge clk_i);
    mreq = req;
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
      if (!dstall_o) begin
        done  = 1'b1;
        rdata = data_o;
        err   = derr_o;
      end
    end
    mreq = '0;
    if (!done) begin
      errors++;
      $display("Data access to %h got no response", addr);
    end
    if (write && addr < addr_t'(MEM_BYTES)) begin
      model_store(addr, wdata, size);
    end
  endtask

  // A one-cycle kill starts a clean fetch of the new pc
  task automatic start_fetch(input addr_t pc);
    @(negedge clk_i);
    pc_i    = pc;
    ikill_i = 1'b1;
    @(negedge clk_i);
    ikill_i = 1'b0;
  endtask

  task automatic wait_fetch(output word_t instr, output logic err);
    int   cycles;
    logic done;
    instr  = '0;
    err    = 1'b0;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
      if (!istall_o) begin
        done  = 1'b1;
        instr = instr_o;
        err   = ierr_o;
      end
    end
    if (!done) begin
      errors++;
      $display("Fetch of pc %h never completed", pc_i);
    end
  endtask

  task automatic reset_state();
    int start;
    start = errors;
    check_bit("istall_o", istall_o, 1'b1);
    check_bit("dstall_o", dstall_o, 1'b0);
    check_bit("derr_o", derr_o, 1'b0);
    check_bit("ierr_o", ierr_o, 1'b0);
    finish_test("reset_state", start);
  endtask

  task automatic word_roundtrip();
    int    start;
    addr_t addrs[$];
    addr_t a;
    word_t rd;
    logic  err;
    start = errors;
    for (int i = 0; i < 16; i++) begin
      a = rand_word_addr();
      addrs.push_back(a);
      data_access(a, next_rand(), `TITAN_SIZE_WORD, 1'b0, 1'b1, rd, err);
      check_bit("derr_o", err, 1'b0);
    end
    foreach (addrs[i]) begin
      data_access(addrs[i], '0, `TITAN_SIZE_WORD, 1'b0, 1'b0, rd, err);
      check_word("data_o", rd, model_word(addrs[i]));
      check_bit("derr_o", err, 1'b0);
    end
    finish_test("word_roundtrip", start);
  endtask

  task automatic subword_store();
    int    start;
    addr_t base;
    size_t sz;
    word_t rd;
    logic  err;
    start = errors;
    for (int off = 0; off < 4; off++) begin
      for (int h = 0; h < 2; h++) begin
        sz = (h == 1) ? `TITAN_SIZE_HALF : `TITAN_SIZE_BYTE;
        if (h == 0 || off % 2 == 0) begin
          base = rand_word_addr();
          data_access(base, next_rand(), `TITAN_SIZE_WORD, 1'b0, 1'b1, rd, err);
          data_access(base + addr_t'(off), next_rand(), sz, 1'b0, 1'b1, rd, err);
          check_bit("derr_o", err, 1'b0);
          data_access(base, '0, `TITAN_SIZE_WORD, 1'b0, 1'b0, rd, err);
          check_word("data_o", rd, model_word(base));
        end
      end
    end
    finish_test("subword_store", start);
  endtask

  task automatic load_extension();
    int    start;
    addr_t a;
    word_t d;
    word_t rd;
    logic  err;
    start = errors;
    for (int i = 0; i < 4; i++) begin
      a = rand_word_addr();
      d = next_rand();
      // Top bit of every byte set, then every one clear
      d = (i % 2 == 0) ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);
      data_access(a, d, `TITAN_SIZE_WORD, 1'b0, 1'b1, rd, err);
      for (int off = 0; off < 4; off++) begin
        for (int u = 0; u < 2; u++) begin
          data_access(a + addr_t'(off), '0, `TITAN_SIZE_BYTE, 1'(u), 1'b0, rd, err);
          check_word("data_o", rd, expect_load(a + addr_t'(off), `TITAN_SIZE_BYTE, 1'(u)));
          if (off % 2 == 0) begin
            data_access(a + addr_t'(off), '0, `TITAN_SIZE_HALF, 1'(u), 1'b0, rd, err);
            check_word("data_o", rd,
                       expect_load(a + addr_t'(off), `TITAN_SIZE_HALF, 1'(u)));
          end
        end
      end
    end
    finish_test("load_extension", start);
  endtask

  task automatic fetch_words();
    int    start;
    addr_t a;
    word_t rd;
    word_t instr;
    logic  err;
    start = errors;
    a     = '0;
    for (int i = 0; i < 8; i++) begin
      a = rand_word_addr();
      data_access(a, next_rand(), `TITAN_SIZE_WORD, 1'b0, 1'b1, rd, err);
      start_fetch(a);
      wait_fetch(instr, err);
      check_word("instr_o", instr, model_word(a));
      check_bit("ierr_o", err, 1'b0);
    end
    start_fetch(a + 32'd2);
    for (int c = 0; c < 20; c++) begin
      @(negedge clk_i);
      check_bit("istall_o", istall_o, 1'b1);
    end
    finish_test("fetch_words", start);
  endtask

  task automatic bad_address();
    int    start;
    addr_t a;
    addr_t bad;
    word_t rd;
    logic  err;
    start = errors;
    for (int i = 0; i < 6; i++) begin
      a = rand_word_addr();
      data_access(a, next_rand(), `TITAN_SIZE_WORD, 1'b0, 1'b1, rd, err);
      // Both forms alias the in-range word by their low index bits
      bad = (i % 2 == 0) ? a + addr_t'(MEM_BYTES) : a | 32'h8000_0000;
      data_access(bad, next_rand(), size_t'(i % 3), 1'b0, 1'b1, rd, err);
      check_bit("derr_o", err, 1'b1);
      data_access(bad, '0, `TITAN_SIZE_WORD, 1'b0, 1'b0, rd, err);
      check_bit("derr_o", err, 1'b1);
      data_access(a, '0, `TITAN_SIZE_WORD, 1'b0, 1'b0, rd, err);
      check_word("data_o", rd, model_word(a));
      check_bit("derr_o", err, 1'b0);
    end
    finish_test("bad_address", start);
  endtask

  task automatic fetch_kill();
    int    start;
    addr_t a_old;
    addr_t a_new;
    word_t d;
    word_t rd;
    word_t instr;
    logic  err;
    start = errors;
    a_old = rand_word_addr();
    a_new = a_old ^ 32'h0000_0040;
    d     = next_rand();
    data_access(a_old, d, `TITAN_SIZE_WORD, 1'b0, 1'b1, rd, err);
    data_access(a_new, ~d, `TITAN_SIZE_WORD, 1'b0, 1'b1, rd, err);
    for (int delay = 1; delay < 4; delay++) begin
      start_fetch(a_old);
      for (int c = 0; c < delay; c++) begin
        @(negedge clk_i);
        if (!istall_o) begin
          errors++;
          $display("Fetch of the old pc finished before the kill");
        end
      end
      pc_i    = a_new;
      ikill_i = 1'b1;
      @(negedge clk_i);
      check_bit("istall_o", istall_o, 1'b1);
      ikill_i = 1'b0;
      wait_fetch(instr, err);
      check_word("instr_o", instr, model_word(a_new));
      check_bit("ierr_o", err, 1'b0);
    end
    finish_test("fetch_kill", start);
  endtask

  initial begin
    rng     = 32'd19;
    errors  = 0;
    checks  = 0;
    tests   = 0;
    rst_i   = 1'b1;
    pc_i    = '0;
    ikill_i = 1'b0;
    mreq    = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_state();
    rst_i = 1'b0;
    word_roundtrip();
    subword_store();
    load_extension();
    fetch_words();
    bad_address();
    fetch_kill();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* titan_cfg.svh */
`ifndef TITAN_CFG_SVH
`define TITAN_CFG_SVH

// Data and address width
`define TITAN_XLEN 32

// Scratchpad depth in words
`define TITAN_MEM_WORDS 256

// Cycles from first stb to ack or err
`define TITAN_MEM_WAIT 2

// Access size codes
`define TITAN_SIZE_BYTE 2'd0
`define TITAN_SIZE_HALF 2'd1
`define TITAN_SIZE_WORD 2'd2

`endif

/* titan_dport.sv */
`default_nettype none

module titan_dport (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire titan_pkg::mem_req_t req_i,
  input  wire titan_pkg::bsel_t   sel_i,
  input  wire titan_pkg::word_t   wdata_i,
  output titan_pkg::wb_req_t      dbus_o,
  input  wire titan_pkg::wb_rsp_t dbus_i,
  output logic                    dstall_o,
  output logic                    derr_o
);
  import titan_pkg::*;

  dport_state_e state_q;
  wb_req_t      bus_q;
  logic         req_valid;
  logic         xfer_end;

  assign req_valid = req_i.read || req_i.write;
  assign xfer_end  = (state_q == XFER) && (dbus_i.ack || dbus_i.err);

  always_ff @(posedge clk_i) begin
    // Payload captured at request time, held through XFER
    if (state_q == IDLE) begin
      bus_q.adr <= req_i.addr;
      bus_q.dat <= wdata_i;
      bus_q.sel <= sel_i;
    end
    if (rst_i) begin
      state_q   <= IDLE;
      bus_q.cyc <= 1'b0;
      bus_q.stb <= 1'b0;
      bus_q.we  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_valid) begin
            state_q   <= XFER;
            bus_q.cyc <= 1'b1;
            bus_q.stb <= 1'b1;
            bus_q.we  <= req_i.write;
          end
        end
        XFER: begin
          if (dbus_i.ack || dbus_i.err) begin
            state_q   <= IDLE;
            bus_q.cyc <= 1'b0;
            bus_q.stb <= 1'b0;
            bus_q.we  <= 1'b0;
          end
        end
        default: begin
          state_q   <= IDLE;
          bus_q.cyc <= 1'b0;
          bus_q.stb <= 1'b0;
          bus_q.we  <= 1'b0;
        end
      endcase
    end
  end

  assign dbus_o   = bus_q;
  assign dstall_o = (state_q == IDLE) ? req_valid : !xfer_end;
  assign derr_o   = xfer_end && dbus_i.err;

endmodule

`default_nettype wire

/* titan_ifetch.sv */
`default_nettype none

module titan_ifetch (
  input  wire                clk_i,
  input  wire                rst_i,
  input  wire titan_pkg::addr_t   pc_i,
  input  wire                ikill_i,
  output titan_pkg::wb_req_t ibus_o,
  input  wire titan_pkg::wb_rsp_t ibus_i,
  output titan_pkg::word_t   instr_o,
  output logic               istall_o,
  output logic               ierr_o
);
  import titan_pkg::*;

  ifetch_state_e state_q;
  logic          cyc_q;
  addr_t         adr_q;
  logic          pc_aligned;
  logic          fetch_end;

  assign pc_aligned = (pc_i[1:0] == 2'b00);

  // A response in the kill cycle is thrown away
  assign fetch_end = (state_q == IDLE_FETCH) && cyc_q && !ikill_i &&
                     (ibus_i.ack || ibus_i.err);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE_FETCH;
      cyc_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE_FETCH: begin
          if (ikill_i) begin
            cyc_q   <= 1'b0;
            state_q <= KILL;
          end else if (!cyc_q) begin
            // Misaligned pc never starts a cycle
            cyc_q <= pc_aligned;
          end else if (ibus_i.ack || ibus_i.err) begin
            cyc_q <= 1'b0;
          end
        end
        KILL: begin
          state_q <= IDLE_FETCH;
        end
        default: begin
          state_q <= IDLE_FETCH;
          cyc_q   <= 1'b0;
        end
      endcase
    end
  end

  // Address follows pc while no cycle is open
  always_ff @(posedge clk_i) begin
    if (!cyc_q) begin
      adr_q <= pc_i;
    end
  end

  always_comb begin
    ibus_o.adr = adr_q;
    ibus_o.dat = '0;
    ibus_o.sel = '1;
    // Kill drops the strobe in the same cycle
    ibus_o.cyc = cyc_q && !ikill_i;
    ibus_o.stb = cyc_q && !ikill_i;
    ibus_o.we  = 1'b0;
  end

  assign instr_o  = ibus_i.dat;
  assign istall_o = !fetch_end;
  assign ierr_o   = fetch_end && ibus_i.err;

endmodule

`default_nettype wire

/* titan_lsu.f */
+incdir+.
titan_pkg.sv
titan_ifetch.sv
titan_lsu_align.sv
titan_dport.sv
titan_lsu.sv
titan_scratchpad.sv
titan_lsu_top.sv
tb_titan_lsu.sv

/* titan_lsu.sv */
`default_nettype none

module titan_lsu (
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire titan_pkg::addr_t    pc_i,
  input  wire                      ikill_i,
  output titan_pkg::word_t         instr_o,
  output logic                     istall_o,
  output logic                     ierr_o,
  input  wire titan_pkg::mem_req_t mreq_i,
  output titan_pkg::word_t         data_o,
  output logic                     dstall_o,
  output logic                     derr_o,
  output titan_pkg::wb_req_t       ibus_o,
  input  wire titan_pkg::wb_rsp_t  ibus_i,
  output titan_pkg::wb_req_t       dbus_o,
  input  wire titan_pkg::wb_rsp_t  dbus_i
);
  import titan_pkg::*;

  bsel_t sel;
  word_t wdata;

  titan_ifetch u_ifetch (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .pc_i     (pc_i),
    .ikill_i  (ikill_i),
    .ibus_o   (ibus_o),
    .ibus_i   (ibus_i),
    .instr_o  (instr_o),
    .istall_o (istall_o),
    .ierr_o   (ierr_o)
  );

  // Load data is aligned straight from the bus response
  titan_lsu_align u_align (
    .req_i   (mreq_i),
    .rdata_i (dbus_i.dat),
    .sel_o   (sel),
    .wdata_o (wdata),
    .data_o  (data_o)
  );

  titan_dport u_dport (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (mreq_i),
    .sel_i    (sel),
    .wdata_i  (wdata),
    .dbus_o   (dbus_o),
    .dbus_i   (dbus_i),
    .dstall_o (dstall_o),
    .derr_o   (derr_o)
  );

endmodule

`default_nettype wire

/* titan_lsu_align.sv */
`default_nettype none

`include "titan_cfg.svh"

module titan_lsu_align (
  input  wire titan_pkg::mem_req_t req_i,
  input  wire titan_pkg::word_t    rdata_i,
  output titan_pkg::bsel_t         sel_o,
  output titan_pkg::word_t         wdata_o,
  output titan_pkg::word_t         data_o
);
  import titan_pkg::*;

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic        ext;

  // Lane enables and store data replicated into every lane
  always_comb begin
    case (req_i.size)
      `TITAN_SIZE_BYTE: begin
        sel_o   = bsel_t'(4'b0001 << req_i.addr[1:0]);
        wdata_o = {4{req_i.wdata[7:0]}};
      end
      `TITAN_SIZE_HALF: begin
        sel_o   = req_i.addr[1] ? 4'b1100 : 4'b0011;
        wdata_o = {2{req_i.wdata[15:0]}};
      end
      default: begin
        sel_o   = 4'b1111;
        wdata_o = req_i.wdata;
      end
    endcase
  end

  // Lane 2 sits at 23..16, lane 3 at 31..24
  always_comb begin
    case (req_i.addr[1:0])
      2'd0:    ld_byte = rdata_i[7:0];
      2'd1:    ld_byte = rdata_i[15:8];
      2'd2:    ld_byte = rdata_i[23:16];
      default: ld_byte = rdata_i[31:24];
    endcase
    ld_half = req_i.addr[1] ? rdata_i[31:16] : rdata_i[15:0];
  end

  always_comb begin
    case (req_i.size)
      `TITAN_SIZE_BYTE: begin
        ext    = !req_i.is_unsigned && ld_byte[7];
        data_o = {{24{ext}}, ld_byte};
      end
      `TITAN_SIZE_HALF: begin
        ext    = !req_i.is_unsigned && ld_half[15];
        data_o = {{16{ext}}, ld_half};
      end
      default: begin
        ext    = 1'b0;
        data_o = rdata_i;
      end
    endcase
  end

endmodule

`default_nettype wire

/* titan_lsu_top.sv */
`default_nettype none

module titan_lsu_top (
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire titan_pkg::addr_t    pc_i,
  input  wire                      ikill_i,
  output titan_pkg::word_t         instr_o,
  output logic                     istall_o,
  output logic                     ierr_o,
  input  wire titan_pkg::mem_req_t mreq_i,
  output titan_pkg::word_t         data_o,
  output logic                     dstall_o,
  output logic                     derr_o
);
  import titan_pkg::*;

  wb_req_t ibus_req;
  wb_rsp_t ibus_rsp;
  wb_req_t dbus_req;
  wb_rsp_t dbus_rsp;

  titan_lsu u_lsu (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .pc_i     (pc_i),
    .ikill_i  (ikill_i),
    .instr_o  (instr_o),
    .istall_o (istall_o),
    .ierr_o   (ierr_o),
    .mreq_i   (mreq_i),
    .data_o   (data_o),
    .dstall_o (dstall_o),
    .derr_o   (derr_o),
    .ibus_o   (ibus_req),
    .ibus_i   (ibus_rsp),
    .dbus_o   (dbus_req),
    .dbus_i   (dbus_rsp)
  );

  titan_scratchpad u_mem (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .ibus_i (ibus_req),
    .ibus_o (ibus_rsp),
    .dbus_i (dbus_req),
    .dbus_o (dbus_rsp)
  );

endmodule

`default_nettype wire

/* titan_pkg.sv */
`default_nettype none

`include "titan_cfg.svh"

package titan_pkg;

  typedef logic [`TITAN_XLEN-1:0]   word_t;
  typedef logic [`TITAN_XLEN-1:0]   addr_t;
  typedef logic [`TITAN_XLEN/8-1:0] bsel_t;
  typedef logic [1:0]               size_t;

  // Core side data request
  typedef struct packed {
    addr_t addr;
    word_t wdata;
    size_t size;
    logic  is_unsigned;
    logic  read;
    logic  write;
  } mem_req_t;

  typedef struct packed {
    addr_t adr;
    word_t dat;
    bsel_t sel;
    logic  cyc;
    logic  stb;
    logic  we;
  } wb_req_t;

  typedef struct packed {
    word_t dat;
    logic  ack;
    logic  err;
  } wb_rsp_t;

  typedef enum logic {IDLE_FETCH, KILL} ifetch_state_e;

  typedef enum logic {IDLE, XFER} dport_state_e;

endpackage

`default_nettype wire

/* titan_scratchpad.sv */
`default_nettype none

`include "titan_cfg.svh"

module titan_scratchpad (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire titan_pkg::wb_req_t ibus_i,
  output titan_pkg::wb_rsp_t      ibus_o,
  input  wire titan_pkg::wb_req_t dbus_i,
  output titan_pkg::wb_rsp_t      dbus_o
);
  import titan_pkg::*;

  localparam int unsigned IDX_W = $clog2(`TITAN_MEM_WORDS);
  localparam int unsigned CNT_W = $clog2(`TITAN_MEM_WAIT + 2);
  localparam int unsigned NBUS  = 2;
  localparam int unsigned LANES = `TITAN_XLEN / 8;

  word_t            mem [`TITAN_MEM_WORDS];
  wb_req_t          bus_req [NBUS];
  wb_rsp_t          bus_rsp [NBUS];
  logic [CNT_W-1:0] wait_cnt [NBUS];
  logic [IDX_W-1:0] idx [NBUS];
  logic [NBUS-1:0]  active;
  logic [NBUS-1:0]  done;
  logic [NBUS-1:0]  in_range;

  // Bus 0 fetch, bus 1 data
  assign bus_req[0] = ibus_i;
  assign bus_req[1] = dbus_i;
  assign ibus_o     = bus_rsp[0];
  assign dbus_o     = bus_rsp[1];

  always_comb begin
    for (int b = 0; b < NBUS; b++) begin
      active[b]     = bus_req[b].cyc && bus_req[b].stb;
      in_range[b]   = (bus_req[b].adr >> 2) < addr_t'(`TITAN_MEM_WORDS);
      idx[b]        = bus_req[b].adr[IDX_W+1:2];
      done[b]       = active[b] && (wait_cnt[b] == CNT_W'(`TITAN_MEM_WAIT));
      bus_rsp[b].ack = done[b] && in_range[b];
      bus_rsp[b].err = done[b] && !in_range[b];
      bus_rsp[b].dat = in_range[b] ? mem[idx[b]] : '0;
    end
  end

  // Count restarts whenever stb falls or a response goes out
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < NBUS; b++) begin
      if (rst_i) begin
        wait_cnt[b] <= '0;
      end else if (!active[b] || done[b]) begin
        wait_cnt[b] <= '0;
      end else begin
        wait_cnt[b] <= wait_cnt[b] + 1'b1;
      end
    end
  end

  // Only the data bus writes, and only on ack
  always_ff @(posedge clk_i) begin
    if (bus_rsp[1].ack && bus_req[1].we) begin
      for (int l = 0; l < LANES; l++) begin
        if (bus_req[1].sel[l]) begin
          mem[idx[1]][8*l +: 8] <= bus_req[1].dat[8*l +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire
